// ==== Makefile ====
# Verilator build and run for the fetch front end testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       := tb_fetch_top
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := All tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides the result, not the simulator exit code
run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== filelist.f ====
hdl/fetch_pkg.sv
hdl/fetch_cfg.sv
hdl/pc_gen.sv
hdl/ifetch.sv
hdl/iqueue.sv
hdl/fetch_top.sv
tb/tb_fetch_top.sv

// ==== hdl/fetch_cfg.sv ====
// fetch configuration registers
// holds the fetch enable, the redirect target and a counter of
// instructions handed to decode. a target write flushes the front end
// for one cycle and presents the new pc to pc_gen
`timescale 1ns/10ps

module fetch_cfg (
	input  logic                        CLK,
	input  logic                        rst_n,
	input  logic                        cfg_we,
	input  fetch_pkg::cfg_reg_e         cfg_addr,
	input  logic [fetch_pkg::XLEN-1:0]  cfg_wdata,
	input  logic                        instr_valid,
	input  logic                        instr_ready,
	output logic [fetch_pkg::XLEN-1:0]  cfg_rdata,
	output logic                        fetch_en,
	output logic                        flush,
	output logic [fetch_pkg::XLEN-1:0]  redirect_pc
);

	logic [fetch_pkg::CNT_W-1:0] count;   // delivered instructions
	logic                        wr_ctrl;
	logic                        wr_target;

	assign wr_ctrl   = cfg_we & (cfg_addr == fetch_pkg::CFG_CTRL);
	assign wr_target = cfg_we & (cfg_addr == fetch_pkg::CFG_TARGET);

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			fetch_en    <= 1'b0;
			flush       <= 1'b0;
			redirect_pc <= fetch_pkg::RESET_PC;
			count       <= '0;
		end else begin
			flush <= wr_target;                // single cycle pulse after the write
			if (wr_ctrl)
				fetch_en <= cfg_wdata[0];
			if (wr_target)
				redirect_pc <= cfg_wdata;      // valid in the flush cycle
			if (instr_valid && instr_ready)
				count <= count + 1'b1;         // one per decode transfer
		end
	end

	// combinational readback
	always_comb begin
		cfg_rdata = '0;
		case (cfg_addr)
			fetch_pkg::CFG_CTRL:   cfg_rdata[0] = fetch_en;
			fetch_pkg::CFG_TARGET: cfg_rdata = redirect_pc;
			fetch_pkg::CFG_COUNT:  cfg_rdata[fetch_pkg::CNT_W-1:0] = count;
			default:               cfg_rdata = '0;
		endcase
	end

endmodule

// ==== hdl/fetch_pkg.sv ====
// fetch front end shared definitions
// widths, reset pc, instruction queue sizing, config register map
// and the ifetch sequencer states
package fetch_pkg;

	// ****************************************
	// datapath widths
	// ****************************************
	localparam int XLEN    = 64;            // pc and fetch packet width
	localparam int BUS_AW  = 32;            // instruction memory address width
	localparam int INSTR_W = 32;            // one instruction
	localparam int CNT_W   = 32;            // delivered instruction counter

	// first fetch address out of reset
	localparam logic [XLEN-1:0] RESET_PC = 64'h8000_0000;

	// ****************************************
	// instruction queue sizing
	// ****************************************
	localparam int IQ_DEPTH = 8;                   // instruction slots, power of two
	localparam int IQ_AW    = $clog2(IQ_DEPTH);    // slot pointer width
	localparam int IQ_CW    = IQ_AW + 1;           // occupancy, holds 0..IQ_DEPTH

	localparam logic [IQ_CW-1:0] IQ_FULL   = IQ_CW'(IQ_DEPTH);
	localparam logic [IQ_CW-1:0] PKT_SLOTS = IQ_CW'(2);   // words per 64-bit packet

	// config register map, selected by cfg_addr
	typedef enum logic [1:0] {
		CFG_CTRL   = 2'd0,    // bit 0 is fetch enable, reads back
		CFG_TARGET = 2'd1,    // write redirects fetch to wdata
		CFG_COUNT  = 2'd2     // delivered instruction count, read only
	} cfg_reg_e;

	// ifetch request sequencer
	typedef enum logic [1:0] {
		F_IDLE = 2'd0,    // nothing outstanding
		F_REQ  = 2'd1,    // request on the bus, waiting for ready
		F_WAIT = 2'd2     // request taken, response pending
	} fetch_state_e;

endpackage

// ==== hdl/fetch_top.sv ====
// instruction fetch front end
// pc generator, memory fetch sequencer and instruction queue, steered
// by a small config register block
`timescale 1ns/10ps

module fetch_top (
	input  logic                           CLK,
	input  logic                           rst_n,
	// config port
	input  logic                           cfg_we,
	input  fetch_pkg::cfg_reg_e            cfg_addr,
	input  logic [fetch_pkg::XLEN-1:0]     cfg_wdata,
	output logic [fetch_pkg::XLEN-1:0]     cfg_rdata,
	// instruction memory
	output logic                           mem_req_valid,
	input  logic                           mem_req_ready,
	output logic [fetch_pkg::BUS_AW-1:0]   mem_req_addr,
	input  logic                           mem_rsp_valid,
	output logic                           mem_rsp_ready,
	input  logic [fetch_pkg::XLEN-1:0]     mem_rsp_data,
	// decode side
	output logic                           instr_valid,
	input  logic                           instr_ready,
	output logic [fetch_pkg::XLEN-1:0]     instr_pc,
	output logic [fetch_pkg::INSTR_W-1:0]  instr_data
);

	logic                       fetch_en;
	logic                       flush;         // one cycle, after a target write
	logic [fetch_pkg::XLEN-1:0] redirect_pc;
	logic [fetch_pkg::XLEN-1:0] fetch_addr;
	logic                       fetch_take;
	logic                       pkt_room;
	logic                       pkt_valid;
	logic [fetch_pkg::XLEN-1:0] pkt_pc;
	logic [fetch_pkg::XLEN-1:0] pkt_data;

	fetch_cfg i_fetch_cfg (
		.CLK(CLK), .rst_n(rst_n),
		.cfg_we(cfg_we), .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata),
		.instr_valid(instr_valid), .instr_ready(instr_ready),
		.cfg_rdata(cfg_rdata), .fetch_en(fetch_en),
		.flush(flush), .redirect_pc(redirect_pc)
	);

	pc_gen i_pc_gen (
		.CLK(CLK), .rst_n(rst_n),
		.fetch_take(fetch_take), .flush(flush),
		.redirect_pc(redirect_pc), .fetch_addr(fetch_addr)
	);

	ifetch i_ifetch (
		.CLK(CLK), .rst_n(rst_n),
		.fetch_addr(fetch_addr), .fetch_en(fetch_en), .flush(flush), .pkt_room(pkt_room),
		.mem_req_ready(mem_req_ready), .mem_rsp_valid(mem_rsp_valid),
		.mem_rsp_data(mem_rsp_data), .fetch_take(fetch_take),
		.mem_req_valid(mem_req_valid), .mem_req_addr(mem_req_addr),
		.mem_rsp_ready(mem_rsp_ready),
		.pkt_valid(pkt_valid), .pkt_pc(pkt_pc), .pkt_data(pkt_data)
	);

	iqueue i_iqueue (
		.CLK(CLK), .rst_n(rst_n), .flush(flush),
		.pkt_valid(pkt_valid), .pkt_pc(pkt_pc), .pkt_data(pkt_data),
		.instr_ready(instr_ready), .pkt_room(pkt_room),
		.instr_valid(instr_valid), .instr_pc(instr_pc), .instr_data(instr_data)
	);

endmodule

// ==== hdl/ifetch.sv ====
// instruction fetch sequencer
// issues one 64-bit read at a time to the instruction memory, holds
// the pc of the outstanding read and turns each accepted response
// into a one-cycle packet for iqueue. a response whose request was
// made before a flush is taken off the bus and thrown away
`timescale 1ns/10ps

module ifetch (
	input  logic                          CLK,
	input  logic                          rst_n,
	input  logic [fetch_pkg::XLEN-1:0]    fetch_addr,
	input  logic                          fetch_en,
	input  logic                          flush,
	input  logic                          pkt_room,
	input  logic                          mem_req_ready,
	input  logic                          mem_rsp_valid,
	input  logic [fetch_pkg::XLEN-1:0]    mem_rsp_data,
	output logic                          fetch_take,
	output logic                          mem_req_valid,
	output logic [fetch_pkg::BUS_AW-1:0]  mem_req_addr,
	output logic                          mem_rsp_ready,
	output logic                          pkt_valid,
	output logic [fetch_pkg::XLEN-1:0]    pkt_pc,
	output logic [fetch_pkg::XLEN-1:0]    pkt_data
);

	fetch_pkg::fetch_state_e state;
	fetch_pkg::fetch_state_e state_nxt;

	logic [fetch_pkg::XLEN-1:0] pending_pc;   // pc of the read on the bus
	logic                       discard;      // outstanding read went stale
	logic                       req_ok;
	logic                       req_fire;
	logic                       rsp_fire;

	// ****************************************
	// request side
	// ****************************************

	// a packet still in its valid cycle is not yet in the queue count
	assign req_ok     = fetch_en & pkt_room & ~flush & ~pkt_valid;
	assign fetch_take = (state == fetch_pkg::F_IDLE) & req_ok;

	assign mem_req_valid = (state == fetch_pkg::F_REQ);
	assign mem_rsp_ready = (state == fetch_pkg::F_WAIT);
	assign mem_req_addr  = {pending_pc[fetch_pkg::BUS_AW-1:3], 3'b000};   // packet aligned

	assign req_fire = mem_req_valid & mem_req_ready;
	assign rsp_fire = mem_rsp_valid & mem_rsp_ready;

	always_comb begin
		state_nxt = state;
		case (state)
			fetch_pkg::F_IDLE: begin
				if (fetch_take) begin
					state_nxt = fetch_pkg::F_REQ;
				end
			end
			fetch_pkg::F_REQ: begin
				// a flush here still lets the request go out
				if (req_fire) begin
					state_nxt = fetch_pkg::F_WAIT;
				end
			end
			fetch_pkg::F_WAIT: begin
				if (rsp_fire) begin
					state_nxt = fetch_pkg::F_IDLE;
				end
			end
			default: state_nxt = fetch_pkg::F_IDLE;
		endcase
	end

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			state <= fetch_pkg::F_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	// address is held from the take until the response returns
	always_ff @(posedge CLK) begin
		if (fetch_take) begin
			pending_pc <= fetch_addr;
		end
	end

	// ****************************************
	// response side
	// ****************************************
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			discard <= 1'b0;
		end else if (rsp_fire) begin
			discard <= 1'b0;                  // stale data consumed
		end else if (flush && state != fetch_pkg::F_IDLE) begin
			discard <= 1'b1;                  // read in flight belongs to old path
		end
	end

	// flush in the response cycle also kills the packet
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			pkt_valid <= 1'b0;
		end else begin
			pkt_valid <= rsp_fire & ~discard & ~flush;
		end
	end

	always_ff @(posedge CLK) begin
		if (rsp_fire) begin
			pkt_pc   <= pending_pc;      // full pc, bit 2 marks an odd start
			pkt_data <= mem_rsp_data;
		end
	end

endmodule

// ==== hdl/iqueue.sv ====
// instruction queue
// splits each 64-bit fetch packet into two 32-bit instructions and
// buffers them with their pc for decode. a packet that starts on the
// odd word only enqueues its upper half. a flush empties the queue
`timescale 1ns/10ps

module iqueue (
	input  logic                           CLK,
	input  logic                           rst_n,
	input  logic                           flush,
	input  logic                           pkt_valid,
	input  logic [fetch_pkg::XLEN-1:0]     pkt_pc,
	input  logic [fetch_pkg::XLEN-1:0]     pkt_data,
	input  logic                           instr_ready,
	output logic                           pkt_room,
	output logic                           instr_valid,
	output logic [fetch_pkg::XLEN-1:0]     instr_pc,
	output logic [fetch_pkg::INSTR_W-1:0]  instr_data
);

	// slot storage, no reset
	logic [fetch_pkg::XLEN-1:0]    slot_pc    [fetch_pkg::IQ_DEPTH];
	logic [fetch_pkg::INSTR_W-1:0] slot_instr [fetch_pkg::IQ_DEPTH];

	logic [fetch_pkg::IQ_AW-1:0] wr_ptr;
	logic [fetch_pkg::IQ_AW-1:0] wr_ptr_nx;    // second slot of a full packet
	logic [fetch_pkg::IQ_AW-1:0] rd_ptr;
	logic [fetch_pkg::IQ_CW-1:0] count;        // occupied slots
	logic [fetch_pkg::IQ_CW-1:0] wr_num;       // slots written this cycle
	logic [fetch_pkg::IQ_CW-1:0] free_slots;
	logic [fetch_pkg::IQ_CW-1:0] need_slots;
	logic                        wr_en;
	logic                        odd_start;
	logic                        rd_fire;

	assign wr_en     = pkt_valid & ~flush;     // packet in the flush cycle is dropped
	assign odd_start = pkt_pc[2];
	assign wr_ptr_nx = wr_ptr + 1'b1;
	assign rd_fire   = instr_valid & instr_ready;

	always_comb begin
		wr_num = '0;
		if (wr_en) begin
			wr_num = odd_start ? fetch_pkg::PKT_SLOTS - 1'b1 : fetch_pkg::PKT_SLOTS;
		end
	end

	// ****************************************
	// room for the next request
	// ****************************************

	// a packet in its valid cycle is not counted yet, reserve its two slots
	assign free_slots = fetch_pkg::IQ_FULL - count;
	assign need_slots = pkt_valid ? fetch_pkg::PKT_SLOTS + fetch_pkg::PKT_SLOTS
	                              : fetch_pkg::PKT_SLOTS;
	assign pkt_room   = (free_slots >= need_slots);

	// ****************************************
	// pointers and occupancy
	// ****************************************
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else if (flush) begin
			wr_ptr <= '0;     // everything queued is on the old path
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			wr_ptr <= wr_ptr + wr_num[fetch_pkg::IQ_AW-1:0];
			if (rd_fire)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count + wr_num - {{(fetch_pkg::IQ_CW-1){1'b0}}, rd_fire};
		end
	end

	// split the packet, low word first
	always_ff @(posedge CLK) begin
		if (wr_en) begin
			if (odd_start) begin
				slot_pc[wr_ptr]    <= pkt_pc;
				slot_instr[wr_ptr] <= pkt_data[63:32];
			end else begin
				slot_pc[wr_ptr]       <= {pkt_pc[fetch_pkg::XLEN-1:3], 3'b000};
				slot_instr[wr_ptr]    <= pkt_data[31:0];
				slot_pc[wr_ptr_nx]    <= {pkt_pc[fetch_pkg::XLEN-1:3], 3'b100};
				slot_instr[wr_ptr_nx] <= pkt_data[63:32];
			end
		end
	end

	// head of queue to decode
	assign instr_valid = (count != '0);
	assign instr_pc    = slot_pc[rd_ptr];
	assign instr_data  = slot_instr[rd_ptr];

endmodule

// ==== hdl/pc_gen.sv ====
// fetch pc generator
// keeps the full fetch pc. steps to the next 8-byte packet each time
// ifetch takes an address, loads the redirect target on a flush
`timescale 1ns/10ps

module pc_gen (
	input  logic                        CLK,
	input  logic                        rst_n,
	input  logic                        fetch_take,
	input  logic                        flush,
	input  logic [fetch_pkg::XLEN-1:0]  redirect_pc,
	output logic [fetch_pkg::XLEN-1:0]  fetch_addr
);

	logic [fetch_pkg::XLEN-1:0] pc;
	logic [fetch_pkg::XLEN-1:0] pc_seq;    // next sequential packet
	logic [fetch_pkg::XLEN-1:0] pc_nxt;

	// ****************************************
	// next pc
	// ****************************************

	// drop the word offset and step one packet, so an odd-word
	// redirect resumes on the following aligned packet
	assign pc_seq = {pc[fetch_pkg::XLEN-1:3] + 1'b1, 3'b000};

	always_comb begin
		pc_nxt = pc;                 // hold while ifetch is busy
		if (flush) begin
			pc_nxt = redirect_pc;    // flush beats a take in the same cycle
		end else if (fetch_take) begin
			pc_nxt = pc_seq;
		end
	end

	// ****************************************
	// pc register
	// ****************************************
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			pc <= fetch_pkg::RESET_PC;
		end else begin
			pc <= pc_nxt;
		end
	end

	// bit 2 still set here after an odd redirect
	// ifetch does the bus alignment and iqueue skips the low word
	assign fetch_addr = pc;

endmodule

// ==== tb/tb_fetch_top.sv ====
// testbench for the instruction fetch front end
// random latency instruction memory, config writer, decode sink with
// random back-pressure and an in-order pc model checked at every transfer
`timescale 1ns/10ps

module tb_fetch_top;

	logic                           CLK = 1'b0;
	logic                           rst_n = 1'b0;
	logic                           cfg_we = 1'b0;
	fetch_pkg::cfg_reg_e            cfg_addr = fetch_pkg::CFG_CTRL;
	logic [fetch_pkg::XLEN-1:0]     cfg_wdata = '0;
	logic [fetch_pkg::XLEN-1:0]     cfg_rdata;
	logic                           mem_req_valid;
	logic                           mem_req_ready = 1'b0;
	logic [fetch_pkg::BUS_AW-1:0]   mem_req_addr;
	logic                           mem_rsp_valid = 1'b0;
	logic                           mem_rsp_ready;
	logic [fetch_pkg::XLEN-1:0]     mem_rsp_data = '0;
	logic                           instr_valid;
	logic                           instr_ready = 1'b0;
	logic [fetch_pkg::XLEN-1:0]     instr_pc;
	logic [fetch_pkg::INSTR_W-1:0]  instr_data;

	integer      seed = 34142;       // stimulus stream
	integer      mem_seed = 34142;   // memory model has its own stream
	int          error_count = 0;    // checks in the main sequence
	int          mon_errors = 0;     // checks in the decode monitor and memory model
	int          tests_run = 0;
	int          tests_failed = 0;
	int          xfer_count = 0;     // decode transfers seen
	bit          timed_out = 1'b0;
	bit          stall = 1'b1;       // decode holds instr_ready low
	bit          rand_ready = 1'b0;  // random back-pressure
	logic [63:0] base_pc = fetch_pkg::RESET_PC;   // pc of transfer number base_cnt
	int          base_cnt = 0;
	logic [63:0] exp_pc;
	logic [63:0] last_pc = '0;
	int          mem_phase = 0;      // 0 idle, 1 req delay, 2 ready, 3 rsp delay, 4 rsp
	int          mem_cnt = 0;
	logic [31:0] mem_addr = '0;

	fetch_top i_fetch_top (.*);

	always #5 CLK = ~CLK;    // 10 ns period

	// memory contents, a pure function of the byte address
	function automatic logic [31:0] word_at(input logic [63:0] a);
		return a[31:0] ^ 32'h5a5a_0000;
	endfunction

	function automatic int total_errors();
		return error_count + mon_errors;
	endfunction

	// ****************************************
	// instruction memory model
	// ****************************************
	always @(negedge CLK) begin
		if (!rst_n) begin
			mem_phase     = 0;
			mem_req_ready = 1'b0;
			mem_rsp_valid = 1'b0;
		end else begin
			case (mem_phase)
				2: begin                          // request went at the last rising edge
					mem_req_ready = 1'b0;
					mem_cnt       = $unsigned($random(mem_seed)) % 5;
					mem_phase     = 3;
				end
				4: begin                          // back in F_IDLE once the data was taken
					if (mem_rsp_ready !== 1'b0) begin
						$display("ERR %0t mem_rsp_ready exp 0 got %b", $time, mem_rsp_ready);
						mon_errors++;
					end
					mem_rsp_valid = 1'b0;
					mem_phase     = 0;
				end
				default: ;
			endcase
			if (mem_phase == 0 && mem_req_valid) begin
				mem_cnt   = $unsigned($random(mem_seed)) % 4;
				mem_phase = 1;
			end
			if (mem_phase == 1) begin
				if (mem_cnt == 0) begin
					mem_req_ready = 1'b1;
					mem_addr      = mem_req_addr;  // held stable by ifetch
					mem_phase     = 2;
				end else
					mem_cnt--;
			end
			if (mem_phase == 3) begin
				if (mem_cnt == 0) begin
					// ifetch waits in F_WAIT for this data
					if (mem_rsp_ready !== 1'b1) begin
						$display("ERR %0t mem_rsp_ready exp 1 got %b", $time, mem_rsp_ready);
						mon_errors++;
					end
					mem_rsp_valid = 1'b1;
					// upper word in the high half
					mem_rsp_data  = {word_at({32'h0, mem_addr + 32'd4}),
					                 word_at({32'h0, mem_addr})};
					mem_phase     = 4;
				end else
					mem_cnt--;
			end
		end
	end

	// ****************************************
	// decode monitor and pc model
	// ****************************************
	always @(posedge CLK) begin
		if (rst_n && instr_valid && instr_ready) begin
			exp_pc = base_pc + 64'(4 * (xfer_count - base_cnt));   // in order, no gaps
			if (instr_pc !== exp_pc) begin
				$display("ERR %0t instr_pc exp %h got %h", $time, exp_pc, instr_pc);
				mon_errors++;
			end
			if (instr_data !== word_at(exp_pc)) begin
				$display("ERR %0t instr_data exp %h got %h", $time, word_at(exp_pc), instr_data);
				mon_errors++;
			end
			last_pc = instr_pc;
			xfer_count++;
		end
	end

	// one cycle, ends on the falling edge with decode ready redriven
	task automatic step();
		@(negedge CLK);
		if (stall)
			instr_ready = 1'b0;
		else if (rand_ready)
			instr_ready = ($random(seed) % 2) != 0;   // about half the time
		else
			instr_ready = 1'b1;
	endtask

	task automatic cfg_write(input fetch_pkg::cfg_reg_e addr, input logic [63:0] data);
		cfg_we    = 1'b1;
		cfg_addr  = addr;
		cfg_wdata = data;
		step();
		cfg_we    = 1'b0;
	endtask

	// decode stalls across the write cycle and the flush cycle
	task automatic redirect(input logic [63:0] target);
		stall       = 1'b1;
		instr_ready = 1'b0;
		base_pc     = target;
		base_cnt    = xfer_count;
		cfg_write(fetch_pkg::CFG_TARGET, target);
		stall = 1'b0;
		step();
	endtask

	task automatic wait_xfers(input int n, input int limit);
		int target;
		int cycles;
		target = xfer_count + n;
		cycles = 0;
		while (xfer_count < target && cycles < limit) begin
			step();
			cycles++;
		end
		if (xfer_count < target) begin
			$display("timeout: %0d instructions not delivered within %0d cycles", n, limit);
			error_count++;
			timed_out = 1'b1;
		end
	endtask

	task automatic wait_rsp_pending(input int limit);
		int cycles;
		cycles = 0;
		while (!mem_rsp_ready && cycles < limit) begin
			step();
			cycles++;
		end
		if (!mem_rsp_ready) begin
			$display("timeout: no memory response pending within %0d cycles", limit);
			error_count++;
			timed_out = 1'b1;
		end
	endtask

	task automatic check_count();
		cfg_addr = fetch_pkg::CFG_COUNT;
		step();                              // combinational read settles
		if (cfg_rdata !== 64'(xfer_count)) begin
			$display("ERR %0t cfg_rdata exp %h got %h", $time, 64'(xfer_count), cfg_rdata);
			error_count++;
		end
	endtask

	task automatic report(input string name, input int errs_before);
		tests_run++;
		if (total_errors() == errs_before)
			$display("test %s: ok", name);
		else begin
			tests_failed++;
			$display("test %s: %0d errors", name, total_errors() - errs_before);
		end
	endtask

	// ****************************************
	// test sequence
	// ****************************************
	initial begin
		int          errs;
		logic [31:0] rnd;
		logic [63:0] target;
		repeat (10) @(negedge CLK);
		rst_n = 1'b1;

		errs = total_errors();
		for (int i = 0; i < 20; i++) begin
			step();
			if (mem_req_valid !== 1'b0) begin
				$display("ERR %0t mem_req_valid exp 0 got %b", $time, mem_req_valid);
				error_count++;
			end
			if (mem_rsp_ready !== 1'b0) begin
				$display("ERR %0t mem_rsp_ready exp 0 got %b", $time, mem_rsp_ready);
				error_count++;
			end
			if (instr_valid !== 1'b0) begin
				$display("ERR %0t instr_valid exp 0 got %b", $time, instr_valid);
				error_count++;
			end
		end
		check_count();
		report("idle after reset", errs);

		errs  = total_errors();
		stall = 1'b0;
		cfg_write(fetch_pkg::CFG_CTRL, 64'd1);
		wait_xfers(64, 2000);
		report("sequential fetch", errs);

		if (!timed_out) begin
			errs       = total_errors();
			rand_ready = 1'b1;
			wait_xfers(100, 4000);
			check_count();
			report("back-pressure", errs);
		end

		if (!timed_out) begin
			errs = total_errors();
			for (int r = 0; r < 8 && !timed_out; r++) begin
				repeat ($unsigned($random(seed)) % 12) step();
				if (r[0])
					wait_rsp_pending(200);      // hit a read in flight
				rnd    = $random(seed);
				target = {32'h0, 32'h8000_0000 | (rnd & 32'h0000_fffc)};
				if (r[0])
					target[2] = 1'b1;           // odd word start
				redirect(target);
				wait_xfers(1, 500);
				if (!timed_out && last_pc !== target) begin
					$display("ERR %0t instr_pc exp %h got %h", $time, target, last_pc);
					error_count++;
				end
				wait_xfers(6, 1000);
			end
			report("redirect", errs);
		end

		if (!timed_out) begin
			errs       = total_errors();
			rand_ready = 1'b0;
			cfg_write(fetch_pkg::CFG_CTRL, 64'd0);
			repeat (30) step();                  // last read completes, queue drains
			for (int i = 0; i < 30; i++) begin
				step();
				if (mem_req_valid !== 1'b0) begin
					$display("ERR %0t mem_req_valid exp 0 got %b", $time, mem_req_valid);
					error_count++;
				end
				if (instr_valid !== 1'b0) begin
					$display("ERR %0t instr_valid exp 0 got %b", $time, instr_valid);
					error_count++;
				end
			end
			check_count();
			report("counter and disable", errs);
		end

		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, total_errors());
		if (total_errors() == 0 && tests_run == 5)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule
